// ==== design/bank_regs.sv ====
`default_nettype none

module bank_regs #(
	parameter logic [7:0] MAP_IDX = 8'd15
) (
	input  wire                      m2,
	input  wire                      map_rst,
	input  wire                      reg_we,
	input  wire [7:0]                cpu_dat,
	input  wire [1:0]                cpu_addr_lo,
	input  wire map_015_pkg::ss_port_t ss,
	output map_015_pkg::bank_state_t state,
	output logic [7:0]               ss_rdat
);

	import map_015_pkg::*;

	logic ss_wr_bank;
	logic ss_wr_mode;

	assign ss_wr_bank = ss.we & (ss.addr == SS_IDX_BANK);
	assign ss_wr_mode = ss.we & (ss.addr == SS_IDX_MODE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mapper register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// save-state access owns the register while active, reset included.
	always_ff @(posedge m2)
	begin
		if (ss.act)
		begin
			if (ss_wr_bank)
			begin
				{state.prg_sub, state.mirror, state.prg} <= {1'b0, ss.wdat[6:0]};
			end
			if (ss_wr_mode)
			begin
				state.mode <= bank_mode_e'(ss.wdat[1:0]);
			end
		end
		else if (map_rst)
		begin
			state.prg     <= 6'd0;
			state.prg_sub <= 1'b0;
			state.mirror  <= 1'b0;
			state.mode    <= MODE_32K;
		end
		else if (reg_we)
		begin
			// data bits 7:0 are sub, mirror, then 6-bit bank.
			{state.prg_sub, state.mirror, state.prg} <= cpu_dat;
			state.mode <= bank_mode_e'(cpu_addr_lo);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// save-state readback.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		case (ss.addr)
			SS_IDX_BANK:
			begin
				ss_rdat = {state.prg_sub, state.mirror, state.prg};
			end
			SS_IDX_MODE:
			begin
				ss_rdat = {6'd0, state.mode};
			end
			SS_IDX_MAPID:
			begin
				ss_rdat = MAP_IDX;
			end
			default:
			begin
				// unused index.
				ss_rdat = 8'hff;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/cpu_bus_decode.sv ====
`default_nettype none

module cpu_bus_decode (
	input  wire [15:0]            cpu_addr,
	input  wire                   cpu_rw,
	output map_015_pkg::cpu_req_t req,
	output logic [12:0]           srm_addr
);

	logic cpu_wr;
	logic in_ram;
	logic in_rom;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address windows.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// work ram at $6000-$7fff.
	assign in_ram = (cpu_addr[15:13] == 3'd3);

	// rom and the mapper register share $8000-$ffff.
	assign in_rom = cpu_addr[15];

	// cpu_rw low is a write cycle.
	assign cpu_wr = !cpu_rw;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// strobes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		req.reg_we = cpu_wr & in_rom;
		req.ram_ce = in_ram;
		req.ram_we = cpu_wr & in_ram;
		req.rom_ce = in_rom;
		// drive prg data onto the bus on reads only.
		req.prg_oe = cpu_rw;
	end

	assign srm_addr = cpu_addr[12:0];

endmodule

`default_nettype wire

// ==== design/map_015_pkg.sv ====
`default_nettype none

package map_015_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// banking modes, taken from cpu address bits 1:0 on a register write.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		MODE_32K  = 2'd0,
		MODE_128K = 2'd1,
		MODE_8K   = 2'd2,
		MODE_16K  = 2'd3
	} bank_mode_e;

	// mapper register contents.
	// mirror set selects horizontal mirroring (ppu a11).
	typedef struct packed {
		logic [5:0] prg;
		logic       prg_sub;
		logic       mirror;
		bank_mode_e mode;
	} bank_state_t;

	// decoded cpu strobes.
	typedef struct packed {
		logic reg_we;
		logic ram_ce;
		logic ram_we;
		logic rom_ce;
		logic prg_oe;
	} cpu_req_t;

	// save-state access.
	typedef struct packed {
		logic       act;
		logic       we;
		logic [7:0] addr;
		logic [7:0] wdat;
	} ss_port_t;

	localparam logic [7:0] SS_IDX_BANK  = 8'd0;
	localparam logic [7:0] SS_IDX_MODE  = 8'd1;
	localparam logic [7:0] SS_IDX_MAPID = 8'd127;

endpackage

`default_nettype wire

// ==== design/map_015_top.sv ====
`default_nettype none

module map_015_top #(
	parameter logic [7:0] MAP_IDX = 8'd15
) (
	input  wire         m2,
	input  wire         map_rst,
	input  wire [15:0]  cpu_addr,
	input  wire [7:0]   cpu_dat,
	input  wire         cpu_rw,
	input  wire [13:0]  ppu_addr,
	input  wire         ppu_oe,
	input  wire         ppu_we,
	input  wire         cfg_chr_ram,
	input  wire         ss_act,
	input  wire         ss_we,
	input  wire [7:0]   ss_addr,
	output logic [19:0] prg_addr,
	output logic        prg_oe,
	output logic [12:0] srm_addr,
	output logic        ram_ce,
	output logic        ram_we,
	output logic        rom_ce,
	output logic [12:0] chr_addr,
	output logic        chr_ce,
	output logic        chr_we,
	output logic        chr_oe,
	output logic        ciram_a10,
	output logic        ciram_ce,
	output logic [7:0]  ss_rdat
);

	import map_015_pkg::*;

	cpu_req_t    req;
	ss_port_t    ss;
	bank_state_t state;

	// save-state writes take data from the cpu bus.
	assign ss = '{act: ss_act, we: ss_we, addr: ss_addr, wdat: cpu_dat};

	assign prg_oe = req.prg_oe;
	assign ram_ce = req.ram_ce;
	assign ram_we = req.ram_we;
	assign rom_ce = req.rom_ce;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cpu side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	cpu_bus_decode i_cpu_bus_decode (
		.cpu_addr (cpu_addr),
		.cpu_rw   (cpu_rw),
		.req      (req),
		.srm_addr (srm_addr)
	);

	bank_regs #(
		.MAP_IDX (MAP_IDX)
	) i_bank_regs (
		.m2          (m2),
		.map_rst     (map_rst),
		.reg_we      (req.reg_we),
		.cpu_dat     (cpu_dat),
		.cpu_addr_lo (cpu_addr[1:0]),
		.ss          (ss),
		.state       (state),
		.ss_rdat     (ss_rdat)
	);

	prg_bank_map i_prg_bank_map (
		.cpu_addr (cpu_addr[14:0]),
		.state    (state),
		.prg_addr (prg_addr)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ppu side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ppu_chr_map i_ppu_chr_map (
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.mirror      (state.mirror),
		.chr_addr    (chr_addr),
		.chr_ce      (chr_ce),
		.chr_we      (chr_we),
		.chr_oe      (chr_oe),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce)
	);

endmodule

`default_nettype wire

// ==== design/ppu_chr_map.sv ====
`default_nettype none

module ppu_chr_map (
	input  wire [13:0] ppu_addr,
	input  wire        ppu_oe,
	input  wire        ppu_we,
	input  wire        cfg_chr_ram,
	input  wire        mirror,
	output logic [12:0] chr_addr,
	output logic       chr_ce,
	output logic       chr_we,
	output logic       chr_oe,
	output logic       ciram_a10,
	output logic       ciram_ce
);

	logic pattern_sel;

	// pattern tables sit below $2000.
	assign pattern_sel = !ppu_addr[13];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// chr memory.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign chr_addr = ppu_addr[12:0];
	assign chr_ce   = pattern_sel;
	assign chr_oe   = !ppu_oe;

	// rom boards never see a chr write.
	assign chr_we = cfg_chr_ram & !ppu_we & pattern_sel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// nametables.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// horizontal uses a11, vertical uses a10.
	assign ciram_a10 = mirror ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce  = pattern_sel;

endmodule

`default_nettype wire

// ==== design/prg_bank_map.sv ====
`default_nettype none

module prg_bank_map (
	input  wire [14:0]                 cpu_addr,
	input  wire map_015_pkg::bank_state_t state,
	output logic [19:0]                prg_addr
);

	import map_015_pkg::*;

	logic [6:0] bank_base;
	logic [6:0] bank_hi;
	logic [6:0] bank;

	// 8k bank number as the register holds it.
	assign bank_base = {state.prg, state.prg_sub};

	// upper half of 128k mode stays on the last bank group.
	assign bank_hi = {6'h3f, state.prg_sub};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bank select per mode, all sums wrap at 7 bits.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		bank = bank_base;
		case (state.mode)
			MODE_32K:
			begin
				bank = ({state.prg, 1'b0} + {5'd0, cpu_addr[14:13]}) ^ {6'd0, state.prg_sub};
			end
			MODE_128K:
			begin
				if (cpu_addr[14])
					bank = bank_hi + {6'd0, cpu_addr[13]};
				else
					bank = bank_base + {6'd0, cpu_addr[13]};
			end
			MODE_8K:
			begin
				// one bank repeated across the window.
				bank = bank_base;
			end
			MODE_16K:
			begin
				bank = bank_base + {6'd0, cpu_addr[13]};
			end
			default:
			begin
				bank = bank_base;
			end
		endcase
	end

	assign prg_addr = {bank, cpu_addr[12:0]};

endmodule

`default_nettype wire

// ==== filelist.f ====
design/map_015_pkg.sv
design/cpu_bus_decode.sv
design/bank_regs.sv
design/prg_bank_map.sv
design/ppu_chr_map.sv
design/map_015_top.sv
tb/map_015_assert.sv
tb/tb_map_015.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the map_015 testbench with Verilator.
# A $fatal or a failed assertion gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_map_015 \
	--Mdir obj_dir -o sim_map_015 \
	-f filelist.f

./obj_dir/sim_map_015

// ==== tb/map_015_assert.sv ====
`default_nettype none

module map_015_assert (
	input wire                         m2,
	input wire                         map_rst,
	input wire                         ss_act,
	input wire                         ram_ce,
	input wire                         ram_we,
	input wire                         chr_ce,
	input wire                         chr_we,
	input wire                         cfg_chr_ram,
	input wire map_015_pkg::bank_mode_e mode
);

	import map_015_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write enables stay inside their windows.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ram_we_in_window: assert property (@(posedge m2) ram_we |-> ram_ce)
		else $error("ram_we active without ram_ce");

	// chr rom boards must never see a write.
	chr_we_needs_ram: assert property (@(posedge m2) chr_we |-> (chr_ce && cfg_chr_ram))
		else $error("chr_we active without chr_ce or without chr ram");

	// reset outside a save-state access clears the mode.
	reset_clears_mode: assert property (@(posedge m2) (map_rst && !ss_act) |=> (mode == MODE_32K))
		else $error("mode not cleared one cycle after reset");

endmodule

bind map_015_top map_015_assert i_map_015_assert (
	.m2          (m2),
	.map_rst     (map_rst),
	.ss_act      (ss_act),
	.ram_ce      (ram_ce),
	.ram_we      (ram_we),
	.chr_ce      (chr_ce),
	.chr_we      (chr_we),
	.cfg_chr_ram (cfg_chr_ram),
	.mode        (state.mode)
);

`default_nettype wire

// ==== tb/tb_map_015.sv ====
`default_nettype none

module tb_map_015;

	import map_015_pkg::*;

	logic m2, map_rst, cpu_rw, ppu_oe, ppu_we, cfg_chr_ram, ss_act, ss_we;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dat, ss_addr, ss_rdat;
	logic [13:0] ppu_addr;
	logic [19:0] prg_addr;
	logic [12:0] srm_addr, chr_addr;
	logic prg_oe, ram_ce, ram_we, rom_ce, chr_ce, chr_we, chr_oe, ciram_a10, ciram_ce;
	logic [15:0] lfsr_q;

	map_015_top #(
		.MAP_IDX (8'd15)
	) i_map_015_top (
		.m2 (m2), .map_rst (map_rst), .cpu_addr (cpu_addr), .cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw), .ppu_addr (ppu_addr), .ppu_oe (ppu_oe), .ppu_we (ppu_we),
		.cfg_chr_ram (cfg_chr_ram), .ss_act (ss_act), .ss_we (ss_we), .ss_addr (ss_addr),
		.prg_addr (prg_addr), .prg_oe (prg_oe), .srm_addr (srm_addr), .ram_ce (ram_ce),
		.ram_we (ram_we), .rom_ce (rom_ce), .chr_addr (chr_addr), .chr_ce (chr_ce),
		.chr_we (chr_we), .chr_oe (chr_oe), .ciram_a10 (ciram_a10), .ciram_ce (ciram_ce),
		.ss_rdat (ss_rdat)
	);

	initial
	begin
		m2 = 1'b0;
		forever #50 m2 = !m2;
	end

	// watchdog on the whole run.
	initial
	begin
		for (int i = 0; i < 2000; i++)
			@(posedge m2);
		$display("timeout, the test sequence did not finish within 2000 cycles");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// 16-bit fibonacci lfsr, taps 16 14 13 11.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// expected 8k bank for a given register and a14:a13.
	function automatic logic [6:0] model_bank(input logic [1:0] mode, input logic [5:0] prg,
		input logic sub, input logic [1:0] a);
		logic [6:0] b;
		case (mode)
			2'd0: b = ({prg, 1'b0} + {5'd0, a}) ^ {6'd0, sub};
			2'd1: b = (a[1] ? {6'h3f, sub} : {prg, sub}) + {6'd0, a[0]};
			2'd2: b = {prg, sub};
			default: b = {prg, sub} + {6'd0, a[0]};
		endcase
		return b;
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: %s, got %0h, expected %0h", $time, msg, actual,
				expected);
			$display("Simulation failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// inputs change a fixed 10 units after the edge.
	task automatic next_cycle();
		@(posedge m2);
		#10;
	endtask

	task automatic settle();
		#20;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu_addr = a;
		cpu_dat  = d;
		cpu_rw   = 1'b0;
		next_cycle();
		cpu_rw = 1'b1;
	endtask

	task automatic read_ss(input logic [7:0] idx, output logic [7:0] v);
		ss_addr = idx;
		settle();
		v = ss_rdat;
		next_cycle();
	endtask

	// rom reads over a14:a13 against the bank model.
	task automatic sweep_prg(input logic [1:0] mode, input logic [5:0] prg, input logic sub,
		input string msg);
		logic [12:0] low;
		for (int a = 0; a < 4; a++)
		begin
			low      = rand_bits(13);
			cpu_addr = {1'b1, 2'(a), low};
			cpu_rw   = 1'b1;
			settle();
			check(prg_addr, {model_bank(mode, prg, sub, 2'(a)), low}, msg);
			next_cycle();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic sweep_after_reset();
		sweep_prg(2'd0, 6'd0, 1'b0, "prg address after reset");
		for (int i = 0; i < 4; i++)
		begin
			ppu_addr = rand_bits(14);
			settle();
			check(ciram_a10, ppu_addr[10], "ciram_a10 after reset");
			next_cycle();
		end
	endtask

	task automatic walk_bank_modes();
		logic [7:0] d, v;
		for (int m = 0; m < 4; m++)
		begin
			d = rand_bits(8);
			cpu_write({14'h2000, 2'(m)}, d);
			read_ss(SS_IDX_BANK, v);
			check(v, d, "bank readback after cpu write");
			read_ss(SS_IDX_MODE, v);
			check(v, m, "mode readback after cpu write");
			sweep_prg(2'(m), d[5:0], d[7], "prg address in banking mode");
		end
	endtask

	task automatic scan_cpu_windows();
		logic [7:0] bank_before, mode_before, v;
		logic [15:0] a;
		logic rw;
		read_ss(SS_IDX_BANK, bank_before);
		read_ss(SS_IDX_MODE, mode_before);
		for (int i = 0; i < 40; i++)
		begin
			a  = rand_bits(16);
			rw = rand_bits(1);
			// writes stay below the register window.
			if (!rw)
				a[15] = 1'b0;
			cpu_addr = a;
			cpu_rw   = rw;
			cpu_dat  = rand_bits(8);
			settle();
			check(ram_ce, a[15:13] == 3'd3, "ram_ce");
			check(ram_we, !rw && (a[15:13] == 3'd3), "ram_we");
			check(rom_ce, a[15], "rom_ce");
			check(prg_oe, rw, "prg_oe");
			check(srm_addr, a[12:0], "srm_addr");
			next_cycle();
		end
		cpu_rw = 1'b1;
		read_ss(SS_IDX_BANK, v);
		check(v, bank_before, "bank changed by a low write");
		read_ss(SS_IDX_MODE, v);
		check(v, mode_before, "mode changed by a low write");
	endtask

	task automatic probe_ppu_side();
		logic [13:0] pa;
		logic oe, we;
		for (int mir = 0; mir < 2; mir++)
		begin
			cpu_write(16'h8000, {1'b0, 1'(mir), 6'h05});
			for (int i = 0; i < 16; i++)
			begin
				pa          = rand_bits(14);
				oe          = rand_bits(1);
				we          = rand_bits(1);
				ppu_addr    = pa;
				ppu_oe      = oe;
				ppu_we      = we;
				cfg_chr_ram = i[0];
				settle();
				check(ciram_a10, (mir == 1) ? pa[11] : pa[10], "ciram_a10");
				check(ciram_ce, !pa[13], "ciram_ce");
				check(chr_ce, !pa[13], "chr_ce");
				check(chr_addr, pa[12:0], "chr_addr");
				check(chr_oe, !oe, "chr_oe");
				check(chr_we, i[0] && !we && !pa[13], "chr_we");
				next_cycle();
			end
		end
		ppu_we      = 1'b1;
		cfg_chr_ram = 1'b0;
	endtask

	task automatic restore_save_state();
		logic [7:0] w0, w1, v;
		w0      = rand_bits(8);
		w1      = rand_bits(8);
		ss_act  = 1'b1;
		ss_we   = 1'b1;
		ss_addr = SS_IDX_BANK;
		cpu_dat = w0;
		next_cycle();
		ss_addr = SS_IDX_MODE;
		cpu_dat = w1;
		next_cycle();
		ss_we = 1'b0;
		// cpu write and reset while the port is active.
		cpu_addr = 16'h8003;
		cpu_dat  = 8'hff;
		cpu_rw   = 1'b0;
		map_rst  = 1'b1;
		next_cycle();
		cpu_rw  = 1'b1;
		map_rst = 1'b0;
		read_ss(SS_IDX_BANK, v);
		check(v, {1'b0, w0[6:0]}, "save-state bank readback");
		read_ss(SS_IDX_MODE, v);
		check(v, {6'd0, w1[1:0]}, "save-state mode readback");
		read_ss(SS_IDX_MAPID, v);
		check(v, 8'd15, "mapper index readback");
		read_ss(8'h40, v);
		check(v, 8'hff, "unused index readback");
		ss_act = 1'b0;
		sweep_prg(w1[1:0], w0[5:0], 1'b0, "prg address after restore");
	endtask

	initial
	begin
		lfsr_q      = 16'd68;
		map_rst     = 1'b1;
		cpu_addr    = 16'h0000;
		cpu_dat     = 8'h00;
		cpu_rw      = 1'b1;
		ppu_addr    = 14'h0000;
		ppu_oe      = 1'b1;
		ppu_we      = 1'b1;
		cfg_chr_ram = 1'b0;
		ss_act      = 1'b0;
		ss_we       = 1'b0;
		ss_addr     = 8'h00;
		repeat (5) @(posedge m2);
		#10;
		map_rst = 1'b0;
		sweep_after_reset();
		walk_bank_modes();
		scan_cpu_windows();
		probe_ppu_side();
		restore_save_state();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
